//--- verilog/tsconf_io_pkg.sv
package tsconf_io_pkg;

  // bus widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  port_lo_t;

  // keyboard columns, active low
  typedef logic [4:0]  keys_t;
  typedef logic [2:0]  border_t;

  // port addresses
  localparam port_lo_t port_fe_lo   = 8'hFE;
  localparam port_lo_t port_saa_lo  = 8'hFF;
  localparam addr_t    port_intmask = 16'h2AAF;

  // #FE write bits, border sits in 2..0
  localparam int fe_tape_bit   = 3;
  localparam int fe_spk_bit    = 4;

  // #FE readback
  localparam int fe_tapein_bit = 6;

  // interrupt mask bits
  localparam int    intmask_frm_bit = 0;
  localparam int    intmask_lin_bit = 1;
  localparam byte_t intmask_reset   = 8'h01;

  // IM2 vectors
  localparam byte_t vect_frm = 8'hFF;
  localparam byte_t vect_lin = 8'hFD;

  // floating data bus
  localparam byte_t idle_bus = 8'hFF;

endpackage

//--- verilog/zbus_if.sv
`timescale 1ns/1ns

interface zbus_if;

  // address and cpu write data
  tsconf_io_pkg::addr_t a;
  tsconf_io_pkg::byte_t d;

  // z80 strobes, all active low
  logic iorq_n;
  logic mreq_n;
  logic rd_n;
  logic wr_n;
  logic m1_n;

  modport sink (
    input a,
    input d,
    input iorq_n,
    input mreq_n,
    input rd_n,
    input wr_n,
    input m1_n
  );

endinterface

//--- verilog/port_decode.sv
`timescale 1ns/1ns

module port_decode (
  zbus_if.sink bus,
  output logic fe_wr,
  output logic fe_rd,
  output logic mask_wr,
  output logic saa_wr_n
);

  tsconf_io_pkg::port_lo_t port_lo;
  logic iowr;
  logic iord;
  logic hit_fe;
  logic hit_saa;
  logic hit_mask;

  assign port_lo = bus.a[7:0];

  // io cycles straight from the pins
  assign iowr = !bus.iorq_n && !bus.wr_n;
  assign iord = !bus.iorq_n && !bus.rd_n;

  // ula style ports only look at the low byte
  assign hit_fe  = (port_lo == tsconf_io_pkg::port_fe_lo);
  assign hit_saa = (port_lo == tsconf_io_pkg::port_saa_lo);

  // ts-config registers need the full address
  assign hit_mask = (bus.a == tsconf_io_pkg::port_intmask);

  assign fe_wr   = iowr && hit_fe;
  assign fe_rd   = iord && hit_fe;
  assign mask_wr = iowr && hit_mask;

  // saa1099 latches on its own wr_n
  assign saa_wr_n = !(iowr && hit_saa);

endmodule

//--- verilog/port_fe.sv
`timescale 1ns/1ns

module port_fe (
  input  logic                   clk_28mhz,
  input  logic                   rst,
  zbus_if.sink                   bus,
  input  logic                   fe_wr,
  input  tsconf_io_pkg::keys_t   keyboard_data,
  input  logic                   tape_in,
  output tsconf_io_pkg::border_t border,
  output logic                   tape_out,
  output logic                   speaker,
  output tsconf_io_pkg::byte_t   fe_value
);

  // only the used bits of the last #fe write are kept
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      border   <= '0;
      tape_out <= 1'b0;
      speaker  <= 1'b0;
    end else if (fe_wr) begin
      border   <= bus.d[2:0];
      tape_out <= bus.d[tsconf_io_pkg::fe_tape_bit];
      speaker  <= bus.d[tsconf_io_pkg::fe_spk_bit];
    end
  end

  // bits 7 and 5 float high
  always_comb begin
    fe_value                              = '1;
    fe_value[4:0]                         = keyboard_data;
    fe_value[tsconf_io_pkg::fe_tapein_bit] = tape_in;
  end

endmodule

//--- verilog/zint.sv
`timescale 1ns/1ns

module zint (
  input  logic                 clk_28mhz,
  input  logic                 rst,
  zbus_if.sink                 bus,
  input  logic                 mask_wr,
  input  logic                 frame_start,
  input  logic                 ftint,
  output logic                 int_n,
  output logic                 vec_ena,
  output tsconf_io_pkg::byte_t vector
);

  logic [1:0]           ftint_r;
  logic                 ft_fall;
  logic                 frm_en;
  logic                 lin_en;
  logic                 int_frm;
  logic                 int_lin;
  logic                 ack_d;
  logic                 ack_first;
  tsconf_io_pkg::byte_t vec_now;
  tsconf_io_pkg::byte_t vec_hold;

  // ft812 pin is asynchronous, two flops then edge detect
  always_ff @(posedge clk_28mhz) begin
    if (rst)
      ftint_r <= 2'b11;
    else
      ftint_r <= {ftint_r[0], ftint};
  end

  assign ft_fall = ftint_r[1] && !ftint_r[0];

  // mask register
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      frm_en <= tsconf_io_pkg::intmask_reset[tsconf_io_pkg::intmask_frm_bit];
      lin_en <= tsconf_io_pkg::intmask_reset[tsconf_io_pkg::intmask_lin_bit];
    end else if (mask_wr) begin
      frm_en <= bus.d[tsconf_io_pkg::intmask_frm_bit];
      lin_en <= bus.d[tsconf_io_pkg::intmask_lin_bit];
    end
  end

  // m1 together with iorq is the im2 acknowledge
  assign vec_ena   = !bus.m1_n && !bus.iorq_n;
  assign ack_first = vec_ena && !ack_d;

  always_ff @(posedge clk_28mhz) begin
    if (rst)
      ack_d <= 1'b0;
    else
      ack_d <= vec_ena;
  end

  // pending flags, a new request wins over the clear
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      int_frm <= 1'b0;
      int_lin <= 1'b0;
    end else begin
      if (ack_first && int_frm)
        int_frm <= 1'b0;
      else if (ack_first && int_lin)
        int_lin <= 1'b0;
      if (frame_start && frm_en)
        int_frm <= 1'b1;
      if (ft_fall && lin_en)
        int_lin <= 1'b1;
    end
  end

  assign int_n = !(int_frm || int_lin);

  // frame has priority over line
  assign vec_now = int_frm ? tsconf_io_pkg::vect_frm :
                   int_lin ? tsconf_io_pkg::vect_lin :
                             tsconf_io_pkg::idle_bus;

  // keep the vector steady once its flag is gone
  always_ff @(posedge clk_28mhz) begin
    if (ack_first)
      vec_hold <= vec_now;
  end

  assign vector = ack_d ? vec_hold : vec_now;

endmodule

//--- verilog/cpu_din_mux.sv
`timescale 1ns/1ns

module cpu_din_mux (
  zbus_if.sink                 bus,
  input  tsconf_io_pkg::byte_t rom_data,
  input  logic                 csrom,
  input  logic                 fe_rd,
  input  tsconf_io_pkg::byte_t fe_value,
  input  logic                 vec_ena,
  input  tsconf_io_pkg::byte_t vector,
  output tsconf_io_pkg::byte_t cpu_di
);

  logic rom_rd;

  // memory read inside the rom window
  assign rom_rd = csrom && !bus.mreq_n && !bus.rd_n;

  always_comb begin
    if (rom_rd)
      cpu_di = rom_data;
    else if (fe_rd)
      cpu_di = fe_value;
    else if (vec_ena)
      cpu_di = vector;
    else
      cpu_di = tsconf_io_pkg::idle_bus;
  end

endmodule

//--- verilog/tsconf_io.sv
`timescale 1ns/1ns

module tsconf_io (
  input  logic                   clk_28mhz,
  input  logic                   rst,
  input  tsconf_io_pkg::addr_t   cpu_a,
  input  tsconf_io_pkg::byte_t   cpu_do,
  input  logic                   iorq_n,
  input  logic                   mreq_n,
  input  logic                   rd_n,
  input  logic                   wr_n,
  input  logic                   m1_n,
  input  tsconf_io_pkg::byte_t   rom_data,
  input  logic                   csrom,
  input  tsconf_io_pkg::keys_t   keyboard_data,
  input  logic                   tape_in,
  input  logic                   ftint,
  input  logic                   frame_start,
  output tsconf_io_pkg::byte_t   cpu_di,
  output logic                   int_n,
  output tsconf_io_pkg::border_t border,
  output logic                   tape_out,
  output logic                   speaker,
  output logic                   saa_wr_n,
  output tsconf_io_pkg::byte_t   keyboard_addr
);

  logic                 fe_wr;
  logic                 fe_rd;
  logic                 mask_wr;
  logic                 vec_ena;
  tsconf_io_pkg::byte_t fe_value;
  tsconf_io_pkg::byte_t vector;

  zbus_if bus ();

  // z80 pins onto the internal bus
  assign bus.a      = cpu_a;
  assign bus.d      = cpu_do;
  assign bus.iorq_n = iorq_n;
  assign bus.mreq_n = mreq_n;
  assign bus.rd_n   = rd_n;
  assign bus.wr_n   = wr_n;
  assign bus.m1_n   = m1_n;

  // keyboard matrix rows come from the high address byte
  assign keyboard_addr = cpu_a[15:8];

  port_decode u_port_decode (
    .bus      (bus),
    .fe_wr    (fe_wr),
    .fe_rd    (fe_rd),
    .mask_wr  (mask_wr),
    .saa_wr_n (saa_wr_n)
  );

  port_fe u_port_fe (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .bus           (bus),
    .fe_wr         (fe_wr),
    .keyboard_data (keyboard_data),
    .tape_in       (tape_in),
    .border        (border),
    .tape_out      (tape_out),
    .speaker       (speaker),
    .fe_value      (fe_value)
  );

  zint u_zint (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .bus         (bus),
    .mask_wr     (mask_wr),
    .frame_start (frame_start),
    .ftint       (ftint),
    .int_n       (int_n),
    .vec_ena     (vec_ena),
    .vector      (vector)
  );

  cpu_din_mux u_cpu_din_mux (
    .bus      (bus),
    .rom_data (rom_data),
    .csrom    (csrom),
    .fe_rd    (fe_rd),
    .fe_value (fe_value),
    .vec_ena  (vec_ena),
    .vector   (vector),
    .cpu_di   (cpu_di)
  );

endmodule

//--- test/tsconf_io_chk.sv
`timescale 1ns/1ns

module tsconf_io_chk (
  input logic                 clk_28mhz,
  input logic                 rst,
  input logic                 iorq_n,
  input logic                 wr_n,
  input logic                 rd_n,
  input logic                 m1_n,
  input logic                 saa_wr_n,
  input logic                 int_n,
  input tsconf_io_pkg::byte_t cpu_di
);

  // nothing pending while in reset
  int_high_in_reset: assert property (@(posedge clk_28mhz) rst |=> int_n)
    else $error("int_n low after a reset cycle");

  // saa strobe only inside an io write
  saa_in_io_write: assert property (@(posedge clk_28mhz) disable iff (rst)
    !saa_wr_n |-> (!iorq_n && !wr_n))
    else $error("saa_wr_n low outside an io write");

  // no read and no acknowledge means a floating bus
  bus_idle_when_quiet: assert property (@(posedge clk_28mhz) disable iff (rst)
    (rd_n && !(!m1_n && !iorq_n)) |-> (cpu_di == tsconf_io_pkg::idle_bus))
    else $error("cpu_di not idle without a read or acknowledge");

endmodule

bind tsconf_io tsconf_io_chk u_chk (
  .clk_28mhz (clk_28mhz),
  .rst       (rst),
  .iorq_n    (iorq_n),
  .wr_n      (wr_n),
  .rd_n      (rd_n),
  .m1_n      (m1_n),
  .saa_wr_n  (saa_wr_n),
  .int_n     (int_n),
  .cpu_di    (cpu_di)
);

//--- test/tb_tsconf_io.sv
`timescale 1ns/1ns

module tb_tsconf_io;

  logic                   clk_28mhz;
  logic                   rst;
  tsconf_io_pkg::addr_t   cpu_a;
  tsconf_io_pkg::byte_t   cpu_do;
  logic                   iorq_n;
  logic                   mreq_n;
  logic                   rd_n;
  logic                   wr_n;
  logic                   m1_n;
  tsconf_io_pkg::byte_t   rom_data;
  logic                   csrom;
  tsconf_io_pkg::keys_t   keyboard_data;
  logic                   tape_in;
  logic                   ftint;
  logic                   frame_start;
  tsconf_io_pkg::byte_t   cpu_di;
  logic                   int_n;
  tsconf_io_pkg::border_t border;
  logic                   tape_out;
  logic                   speaker;
  logic                   saa_wr_n;
  tsconf_io_pkg::byte_t   keyboard_addr;

  integer seed;
  string  test_name;
  // saa_wr_n as seen in the last strobe cycle of a bus task
  logic   saa_seen;

  tsconf_io uut (.*);

  always #2 clk_28mhz = ~clk_28mhz;

  task automatic compare(input string what, input logic [7:0] expected,
                         input logic [7:0] actual);
    if (actual !== expected) begin
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // z80 bus cycles with each strobe held for 3 clocks and sampled before release
  task automatic io_write(input tsconf_io_pkg::addr_t addr, input tsconf_io_pkg::byte_t data);
    cpu_a  = addr;
    cpu_do = data;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    repeat (3) @(negedge clk_28mhz);
    saa_seen = saa_wr_n;
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    @(negedge clk_28mhz);
  endtask

  task automatic io_read(input tsconf_io_pkg::addr_t addr, output tsconf_io_pkg::byte_t data);
    cpu_a  = addr;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    repeat (3) @(negedge clk_28mhz);
    data     = cpu_di;
    saa_seen = saa_wr_n;
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    @(negedge clk_28mhz);
  endtask

  task automatic mem_read(input tsconf_io_pkg::addr_t addr, output tsconf_io_pkg::byte_t data);
    cpu_a  = addr;
    mreq_n = 1'b0;
    rd_n   = 1'b0;
    repeat (3) @(negedge clk_28mhz);
    data   = cpu_di;
    mreq_n = 1'b1;
    rd_n   = 1'b1;
    @(negedge clk_28mhz);
  endtask

  task automatic int_ack(output tsconf_io_pkg::byte_t vec);
    m1_n   = 1'b0;
    iorq_n = 1'b0;
    repeat (3) @(negedge clk_28mhz);
    vec    = cpu_di;
    m1_n   = 1'b1;
    iorq_n = 1'b1;
    @(negedge clk_28mhz);
  endtask

  task automatic frame_pulse();
    frame_start = 1'b1;
    @(negedge clk_28mhz);
    frame_start = 1'b0;
  endtask

  task automatic wait_int_low(input int max_cycles);
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < max_cycles) begin
      @(negedge clk_28mhz);
      n++;
    end
    if (int_n !== 1'b0) begin
      $display("int_n did not go low within %0d cycles in %s", max_cycles, test_name);
      $display("tests failed");
      $fatal(1, "interrupt never raised");
    end
  endtask

  task automatic hold_int_high(input int cycles);
    repeat (cycles) begin
      @(negedge clk_28mhz);
      compare("int_n stays high", 8'd1, 8'(int_n));
    end
  endtask

  task automatic border_and_beeper();
    tsconf_io_pkg::byte_t data;
    tsconf_io_pkg::byte_t other;
    test_name = "fe write";
    data  = 8'($random(seed));
    other = ~data;
    io_write({8'($random(seed)), 8'hFE}, data);
    compare("border", 8'(data[2:0]), 8'(border));
    compare("tape_out", 8'(data[3]), 8'(tape_out));
    compare("speaker", 8'(data[4]), 8'(speaker));
    // a #FD write must leave the register alone
    io_write({8'($random(seed)), 8'hFD}, other);
    compare("border after #FD", 8'(data[2:0]), 8'(border));
    compare("tape_out after #FD", 8'(data[3]), 8'(tape_out));
    compare("speaker after #FD", 8'(data[4]), 8'(speaker));
  endtask

  task automatic read_paths();
    tsconf_io_pkg::keys_t keys;
    tsconf_io_pkg::byte_t hi;
    tsconf_io_pkg::byte_t rom;
    tsconf_io_pkg::byte_t rdata;
    logic                 tin;
    test_name = "read mux";
    keys = 5'($random(seed));
    tin  = 1'($random(seed));
    hi   = 8'($random(seed));
    rom  = 8'($random(seed));
    keyboard_data = keys;
    tape_in       = tin;
    io_read({hi, 8'hFE}, rdata);
    compare("#FE readback", {1'b1, tin, 1'b1, keys}, rdata);
    compare("keyboard_addr", hi, keyboard_addr);
    rom_data = rom;
    csrom    = 1'b1;
    mem_read(16'($random(seed)), rdata);
    compare("rom read", rom, rdata);
    csrom = 1'b0;
    io_read(16'h00F7, rdata);
    compare("unused port", 8'hFF, rdata);
  endtask

  task automatic saa_strobe();
    tsconf_io_pkg::byte_t rdata;
    test_name = "saa strobe";
    io_write(16'h00FF, 8'($random(seed)));
    compare("write #FF", 8'd0, 8'(saa_seen));
    io_write(16'h00FE, 8'($random(seed)));
    compare("write #FE", 8'd1, 8'(saa_seen));
    io_read(16'h00FF, rdata);
    compare("read #FF", 8'd1, 8'(saa_seen));
  endtask

  task automatic frame_interrupt();
    tsconf_io_pkg::byte_t vec;
    test_name = "frame int";
    frame_pulse();
    wait_int_low(2);
    int_ack(vec);
    compare("frame vector", 8'hFF, vec);
    compare("int_n after ack", 8'd1, 8'(int_n));
  endtask

  task automatic masked_ftint();
    tsconf_io_pkg::byte_t vec;
    test_name = "ft812 int";
    // reset mask only lets the frame source through
    ftint = 1'b0;
    hold_int_high(8);
    ftint = 1'b1;
    repeat (3) @(negedge clk_28mhz);
    io_write(16'h2AAF, 8'h02);
    ftint = 1'b0;
    wait_int_low(8);
    int_ack(vec);
    compare("line vector", 8'hFD, vec);
    compare("int_n after ack", 8'd1, 8'(int_n));
    ftint = 1'b1;
    frame_pulse();
    hold_int_high(4);
  endtask

  // whole run takes under 300 ns and the limit sits well above it
  initial begin
    #4000;
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial begin
    seed          = 32'h5486;
    test_name     = "reset";
    clk_28mhz     = 1'b0;
    rst           = 1'b1;
    cpu_a         = '0;
    cpu_do        = '0;
    iorq_n        = 1'b1;
    mreq_n        = 1'b1;
    rd_n          = 1'b1;
    wr_n          = 1'b1;
    m1_n          = 1'b1;
    rom_data      = '0;
    csrom         = 1'b0;
    keyboard_data = '1;
    tape_in       = 1'b0;
    ftint         = 1'b1;
    frame_start   = 1'b0;
    saa_seen      = 1'b1;
    repeat (4) @(negedge clk_28mhz);
    rst = 1'b0;
    @(negedge clk_28mhz);
    compare("int_n", 8'd1, 8'(int_n));
    compare("saa_wr_n", 8'd1, 8'(saa_wr_n));
    compare("border", 8'd0, 8'(border));
    border_and_beeper();
    read_paths();
    saa_strobe();
    frame_interrupt();
    masked_ftint();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- tsconf_io.f
verilog/tsconf_io_pkg.sv
verilog/zbus_if.sv
verilog/port_decode.sv
verilog/port_fe.sv
verilog/zint.sv
verilog/cpu_din_mux.sv
verilog/tsconf_io.sv
test/tsconf_io_chk.sv
test/tb_tsconf_io.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tsconf_io testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tsconf_io \
  -f tsconf_io.f -Mdir obj_dir -o tb_tsconf_io
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_tsconf_io
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0
